// File: include/tau_consts.svh
`ifndef TAU_CONSTS_SVH
`define TAU_CONSTS_SVH

//==================================================
// Vector geometry
//==================================================
// Lanes in one warp
`define VSIZE 4
// Words in one DRAM write line, a power of two
`define CSIZE 8
// Warps (rows) in one block
`define BLK_ROWS 4

//==================================================
// Widths
//==================================================
// Data word
`define DBW 16
// Global word address
`define GBW 16
// Block offset and boundary coordinate
`define WBW 8

`endif

// File: list.f
+incdir+include
verilog/tau_types_pkg.sv
verilog/tau_ctrl_pkg.sv
verilog/tau_ifs.sv
verilog/block_sequencer.sv
verilog/warp_addr_counter.sv
verilog/dram_write_collector.sv
verilog/write_pipeline.sv
verification/write_pipeline_assertions.sv
verification/tb_write_pipeline.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_write_pipeline \
	-f list.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Testbench failed" sim.log; then
	exit 1
fi
grep -q "Testbench passed" sim.log

// File: verification/tb_write_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

module tb_write_pipeline
	import tau_types_pkg::*;
();

localparam int MAXV = 16;
localparam int LW   = `CSIZE*`DBW;

logic       i_clk;
logic       i_rst;
logic       i_bofs_rdy;
logic       o_bofs_ack;
coord_t     i_bofs_x;
coord_t     i_bofs_y;
gaddr_t     i_mofs_start;
gaddr_t     i_ystep;
coord_t     i_bound_x;
coord_t     i_bound_y;
logic       i_alu_dat_rdy;
logic       o_alu_dat_ack;
data_t      i_alu_dat [`VSIZE];
logic       i_blkdone_dval;
logic       o_dramw_rdy;
logic       i_dramw_ack;
gaddr_t     o_dramwa;
data_t      o_dramwd [`CSIZE];
line_mask_t o_dramw_mask;

write_pipeline i_write_pipeline (.*);

bind write_pipeline write_pipeline_assertions u_asrt (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_bofs_rdy    (i_bofs_rdy),
	.o_bofs_ack    (o_bofs_ack),
	.o_alu_dat_ack (o_alu_dat_ack),
	.o_dramw_rdy   (o_dramw_rdy),
	.i_dramw_ack   (i_dramw_ack),
	.o_dramwa      (o_dramwa),
	.o_dramw_mask  (o_dramw_mask)
);

//==================================================
// Vectors, expected writes, counters
//==================================================
int         nvec;
int         v_bx [MAXV];
int         v_by [MAXV];
int         v_mofs [MAXV];
int         v_ystep [MAXV];
int         v_bndx [MAXV];
int         v_bndy [MAXV];
int         v_bp [MAXV];
int         v_count [MAXV];
data_t      alu_vec [`BLK_ROWS][`VSIZE];
gaddr_t     exp_addr [$];
line_mask_t exp_mask [$];
logic [LW-1:0] exp_data [$];
logic [31:0] seed = 32'hbe502b66;
int         cycles;
int         limit;
int         total_errs;
int         tests_ok;
int         tests_bad;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

initial begin
	i_clk = 1'b0;
	forever #4 i_clk = ~i_clk;
end

// Ends the run when a block never retires
initial begin
	cycles = 0;
	wait (limit > 0);
	while (cycles < limit) begin
		@(posedge i_clk);
		cycles++;
	end
	$display("Timeout after %0d cycles, a block did not retire", cycles);
	$display("Testbench failed");
	$finish;
end

// Address, mask and line split rules applied to one block
task automatic model_block(input int idx, output int count);
	int r;
	int l;
	int addr [`VSIZE];
	logic vld [`VSIZE];
	int first;
	int line;
	int base;
	line_mask_t m;
	logic [LW-1:0] d;
	begin
		count = 0;
		for (r = 0; r < `BLK_ROWS; r++) begin
			first = -1;
			for (l = 0; l < `VSIZE; l++) begin
				addr[l] = (v_mofs[idx] + (v_by[idx] + r) * v_ystep[idx] + v_bx[idx] + l)
					& 32'hffff;
				vld[l]  = (v_bx[idx] + l < v_bndx[idx]) && (v_by[idx] + r < v_bndy[idx]);
				if (vld[l] && first < 0)
					first = l;
			end
			if (first >= 0) begin
				base = addr[first] & ~(`CSIZE-1);
				for (line = base; line <= base + `CSIZE; line += `CSIZE) begin
					m = '0;
					d = '0;
					for (l = 0; l < `VSIZE; l++) begin
						if (vld[l] && (addr[l] & ~(`CSIZE-1)) == line) begin
							m[addr[l] % `CSIZE] = 1'b1;
							d[(addr[l] % `CSIZE)*`DBW +: `DBW] = alu_vec[r][l];
						end
					end
					if (m != '0) begin
						exp_addr.push_back(gaddr_t'(line));
						exp_mask.push_back(m);
						exp_data.push_back(d);
						count++;
					end
				end
			end
		end
	end
endtask

task automatic run_block(input int idx);
	int r;
	int l;
	int w;
	int model_cnt;
	int alu_row;
	int dval_wait;
	int writes;
	int errs;
	int acks;
	logic dval_seen;
	logic dval_sent;
	logic alu_fire;
	logic ack_now;
	logic [LW-1:0] act_data;
	begin
		writes    = 0;
		errs      = 0;
		acks      = 0;
		alu_row   = 0;
		dval_seen = 1'b0;
		dval_sent = 1'b0;
		for (r = 0; r < `BLK_ROWS; r++) begin
			for (l = 0; l < `VSIZE; l++) begin
				seed = lcg_next(seed);
				alu_vec[r][l] = seed[31:16];
			end
		end
		model_block(idx, model_cnt);
		if (model_cnt != v_count[idx]) begin
			$display("Fail vec%0d model write count expected %0d actual %0d", idx, v_count[idx],
				model_cnt);
			errs++;
		end
		seed = lcg_next(seed);
		dval_wait = 2 + int'(seed[27:16] % 24);

		@(posedge i_clk);
		i_bofs_x      <= coord_t'(v_bx[idx]);
		i_bofs_y      <= coord_t'(v_by[idx]);
		i_mofs_start  <= gaddr_t'(v_mofs[idx]);
		i_ystep       <= gaddr_t'(v_ystep[idx]);
		i_bound_x     <= coord_t'(v_bndx[idx]);
		i_bound_y     <= coord_t'(v_bndy[idx]);
		i_bofs_rdy    <= 1'b1;
		i_alu_dat_rdy <= 1'b1;
		i_alu_dat     <= alu_vec[0];
		i_dramw_ack   <= 1'b1;

		forever begin
			@(negedge i_clk);
			if (acks > 0 && alu_row == `BLK_ROWS && !o_dramw_rdy && exp_addr.size() == 0)
				break;
			ack_now = o_bofs_ack;
			if (o_bofs_ack) begin
				acks++;
				if (acks > 1) begin
					$display("Block vec%0d acked more than once", idx);
					errs++;
				end
				if (!dval_seen) begin
					$display("Block vec%0d acked before block done", idx);
					errs++;
				end
			end
			if (i_blkdone_dval)
				dval_seen = 1'b1;
			alu_fire = i_alu_dat_rdy && o_alu_dat_ack;
			if (o_dramw_rdy && i_dramw_ack) begin
				writes++;
				act_data = '0;
				for (w = 0; w < `CSIZE; w++) begin
					if (o_dramw_mask[w])
						act_data[w*`DBW +: `DBW] = o_dramwd[w];
				end
				if (exp_addr.size() == 0) begin
					$display("Block vec%0d produced a write that was not expected", idx);
					errs++;
				end else begin
					if (o_dramwa != exp_addr[0]) begin
						$display("Fail vec%0d addr expected %h actual %h", idx, exp_addr[0],
							o_dramwa);
						errs++;
					end
					if (o_dramw_mask != exp_mask[0]) begin
						$display("Fail vec%0d mask expected %h actual %h", idx, exp_mask[0],
							o_dramw_mask);
						errs++;
					end
					if (act_data != exp_data[0]) begin
						$display("Fail vec%0d data expected %h actual %h", idx, exp_data[0],
							act_data);
						errs++;
					end
					void'(exp_addr.pop_front());
					void'(exp_mask.pop_front());
					void'(exp_data.pop_front());
				end
			end

			@(posedge i_clk);
			if (alu_fire)
				alu_row++;
			i_alu_dat_rdy <= (alu_row < `BLK_ROWS);
			if (alu_row < `BLK_ROWS)
				i_alu_dat <= alu_vec[alu_row];
			if (ack_now)
				i_bofs_rdy <= 1'b0;
			// Block-done is a single pulse after a random delay
			if (dval_sent) begin
				i_blkdone_dval <= 1'b0;
			end else if (dval_wait == 0) begin
				i_blkdone_dval <= 1'b1;
				dval_sent = 1'b1;
			end else begin
				dval_wait--;
			end
			seed = lcg_next(seed);
			i_dramw_ack <= (v_bp[idx] == 0) ? 1'b1 : (seed[17:16] != 2'b00);
		end

		if (writes != v_count[idx]) begin
			$display("Fail vec%0d write count expected %0d actual %0d", idx, v_count[idx], writes);
			errs++;
		end
		total_errs += errs;
		if (errs == 0) begin
			tests_ok++;
			$display("vec%0d ok, %0d writes", idx, writes);
		end else begin
			tests_bad++;
			$display("vec%0d failed with %0d errors", idx, errs);
		end
	end
endtask

//==================================================
// Main sequence
//==================================================
initial begin
	int fd;
	int n;
	int k;
	string line;
	i_rst          = 1'b1;
	i_bofs_rdy     = 1'b0;
	i_bofs_x       = '0;
	i_bofs_y       = '0;
	i_mofs_start   = '0;
	i_ystep        = '0;
	i_bound_x      = '0;
	i_bound_y      = '0;
	i_alu_dat_rdy  = 1'b0;
	i_blkdone_dval = 1'b0;
	i_dramw_ack    = 1'b0;
	for (k = 0; k < `VSIZE; k++)
		i_alu_dat[k] = '0;
	nvec       = 0;
	total_errs = 0;
	tests_ok   = 0;
	tests_bad  = 0;
	limit      = 0;

	fd = $fopen("verification/write_pipeline_vectors.txt", "r");
	if (fd == 0) begin
		$display("Could not open the vector file");
		$display("Testbench failed");
		$finish;
	end else begin
		while (!$feof(fd) && nvec < MAXV) begin
			n = $fgets(line, fd);
			if (n > 0 && line[0] != 8'h23) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h", v_bx[nvec], v_by[nvec],
					v_mofs[nvec], v_ystep[nvec], v_bndx[nvec], v_bndy[nvec], v_bp[nvec],
					v_count[nvec]);
				if (n == 8)
					nvec++;
			end
		end
		$fclose(fd);
		limit = 400 * nvec + 100;

		repeat (2) @(posedge i_clk);
		i_rst <= 1'b0;

		for (k = 0; k < nvec; k++)
			run_block(k);

		$display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errs);
		if (total_errs == 0 && nvec > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end
end

endmodule

`default_nettype wire

// File: verification/write_pipeline_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

module write_pipeline_assertions
	import tau_types_pkg::*;
(
	input wire             i_clk,
	input wire             i_rst,
	input wire             i_bofs_rdy,
	input wire             o_bofs_ack,
	input wire             o_alu_dat_ack,
	input wire             o_dramw_rdy,
	input wire             i_dramw_ack,
	input wire gaddr_t     o_dramwa,
	input wire line_mask_t o_dramw_mask
);

// A stalled DRAM write keeps its line and mask
a_dram_hold: assert property (@(posedge i_clk) disable iff (i_rst)
	o_dramw_rdy && !i_dramw_ack |=> o_dramw_rdy && $stable(o_dramwa) && $stable(o_dramw_mask))
	else $error("DRAM write changed while stalled");

// Every write enables at least one word
a_mask_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
	o_dramw_rdy |-> (o_dramw_mask != '0))
	else $error("DRAM write with empty mask");

// No ALU vector is taken while a DRAM write is stalled
a_alu_stall: assert property (@(posedge i_clk) disable iff (i_rst)
	o_dramw_rdy && !i_dramw_ack |=> !o_alu_dat_ack)
	else $error("ALU ack while DRAM write stalled");

// Block ack only while the command is still offered
a_bofs_ack_rdy: assert property (@(posedge i_clk) disable iff (i_rst)
	o_bofs_ack |-> i_bofs_rdy)
	else $error("Block ack without block rdy");

endmodule

`default_nettype wire

// File: verification/write_pipeline_vectors.txt
# Hex columns: bofs_x bofs_y mofs_start ystep bound_x bound_y backpressure writes
# backpressure 1 puts random gaps into the DRAM write ack
00 00 0100 0010 20 20 0 04
06 01 0200 0020 ff ff 0 08
0e 05 0400 0010 10 07 0 02
04 02 0500 0010 00 ff 0 00
05 02 1000 0008 ff ff 1 08
05 00 2000 0018 07 03 1 03
07 00 3000 0040 09 ff 1 08
10 10 0000 0100 ff ff 1 04

// File: verilog/block_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module block_sequencer
	import tau_types_pkg::*, tau_ctrl_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	input  wire         i_bofs_rdy,
	output logic        o_bofs_ack,
	input  wire coord_t i_bofs_x,
	input  wire coord_t i_bofs_y,
	input  wire gaddr_t i_mofs_start,
	input  wire gaddr_t i_ystep,
	input  wire coord_t i_bound_x,
	input  wire coord_t i_bound_y,
	input  wire         i_blkdone_dval,
	block_cmd_if.seq    cmd
);

//==================================================
// State
//==================================================
seq_state_e state;
logic       done_seen;
logic       done_now;
logic       accept;

assign accept   = (state == S_IDLE) && i_bofs_rdy;
// Block-done may land in the same cycle the counter finishes
assign done_now = done_seen || i_blkdone_dval;

assign cmd.rdy    = (state == S_ISSUE);
assign o_bofs_ack = (state == S_RETIRE);

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		state     <= S_IDLE;
		done_seen <= 1'b0;
	end else begin
		if (state != S_IDLE && i_blkdone_dval) begin
			done_seen <= 1'b1;
		end
		case (state)
			S_IDLE: begin
				if (accept) begin
					state <= S_ISSUE;
				end
			end
			S_ISSUE: begin
				if (cmd.ack) begin
					state <= done_now ? S_RETIRE : S_WAIT_DONE;
				end
			end
			S_WAIT_DONE: begin
				if (done_now) begin
					state <= S_RETIRE;
				end
			end
			S_RETIRE: begin
				// Flag belongs to this block only
				state     <= S_IDLE;
				done_seen <= 1'b0;
			end
			default: state <= S_IDLE;
		endcase
	end
end

//==================================================
// Command latch
//==================================================
// Fields stay put until the next block is accepted
always_ff @(posedge i_clk) begin
	if (accept) begin
		cmd.bofs_x     <= i_bofs_x;
		cmd.bofs_y     <= i_bofs_y;
		cmd.mofs_start <= i_mofs_start;
		cmd.ystep      <= i_ystep;
		cmd.bound_x    <= i_bound_x;
		cmd.bound_y    <= i_bound_y;
	end
end

endmodule

`default_nettype wire

// File: verilog/dram_write_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

module dram_write_collector
	import tau_types_pkg::*, tau_ctrl_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	warp_if.dst         warp,
	input  wire         i_alu_dat_rdy,
	output logic        o_alu_dat_ack,
	input  wire data_t  i_alu_dat [`VSIZE],
	output logic        o_dramw_rdy,
	input  wire         i_dramw_ack,
	output gaddr_t      o_dramwa,
	output data_t       o_dramwd [`CSIZE],
	output line_mask_t  o_dramw_mask
);

localparam OFS_BW = $clog2(`CSIZE);
localparam gaddr_t LINE_MASK = ~gaddr_t'(`CSIZE-1);

//==================================================
// Join of warp and ALU vector
//==================================================
col_state_e state;
gaddr_t     lane_addr [`VSIZE];
data_t      lane_dat [`VSIZE];
lane_mask_t lane_vld;
logic       take;
logic       spill;

// Both sides transfer together, only while nothing is pending
assign take          = (state == C_IDLE) && warp.rdy && i_alu_dat_rdy;
assign warp.ack      = take;
assign o_alu_dat_ack = take;
assign o_dramw_rdy   = (state != C_IDLE);

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		state    <= C_IDLE;
		lane_vld <= '0;
	end else begin
		if (take) begin
			lane_vld <= warp.valid;
		end
		case (state)
			C_IDLE: begin
				// Fully masked warps are dropped here
				if (take && |warp.valid) begin
					state <= C_FIRST;
				end
			end
			C_FIRST: begin
				if (i_dramw_ack) begin
					state <= spill ? C_SECOND : C_IDLE;
				end
			end
			C_SECOND: begin
				if (i_dramw_ack) begin
					state <= C_IDLE;
				end
			end
			default: state <= C_IDLE;
		endcase
	end
end

always_ff @(posedge i_clk) begin
	if (take) begin
		lane_addr <= warp.addr;
		lane_dat  <= i_alu_dat;
	end
end

//==================================================
// Line split
//==================================================
gaddr_t lo_line;
gaddr_t hi_line;
gaddr_t cur_line;

// Lowest valid lane sets the lower line
always_comb begin
	lo_line = '0;
	spill   = 1'b0;
	for (int l = `VSIZE-1; l >= 0; l--) begin
		if (lane_vld[l]) begin
			lo_line = lane_addr[l] & LINE_MASK;
		end
	end
	for (int l = 0; l < `VSIZE; l++) begin
		if (lane_vld[l] && (lane_addr[l] & LINE_MASK) != lo_line) begin
			spill = 1'b1;
		end
	end
end

assign hi_line  = lo_line + gaddr_t'(`CSIZE);
assign cur_line = (state == C_SECOND) ? hi_line : lo_line;
assign o_dramwa = cur_line;

// Each lane lands at its address modulo the line size
always_comb begin
	o_dramw_mask = '0;
	for (int w = 0; w < `CSIZE; w++) begin
		o_dramwd[w] = '0;
	end
	for (int l = 0; l < `VSIZE; l++) begin
		if (lane_vld[l] && (lane_addr[l] & LINE_MASK) == cur_line) begin
			o_dramwd[lane_addr[l][OFS_BW-1:0]]     = lane_dat[l];
			o_dramw_mask[lane_addr[l][OFS_BW-1:0]] = 1'b1;
		end
	end
end

endmodule

`default_nettype wire

// File: verilog/tau_ctrl_pkg.sv
`default_nettype none

package tau_ctrl_pkg;

	// Block sequencer
	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT_DONE,
		S_RETIRE
	} seq_state_e;

	// DRAM write collector, one state per pending line
	typedef enum logic [1:0] {
		C_IDLE,
		C_FIRST,
		C_SECOND
	} col_state_e;

endpackage

`default_nettype wire

// File: verilog/tau_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

// Block command from the sequencer to the warp counter
interface block_cmd_if
	import tau_types_pkg::*;
();
	logic   rdy;
	logic   ack;
	coord_t bofs_x;
	coord_t bofs_y;
	gaddr_t mofs_start;
	gaddr_t ystep;
	coord_t bound_x;
	coord_t bound_y;

	modport seq (output rdy, bofs_x, bofs_y, mofs_start, ystep, bound_x, bound_y,
		input ack);
	modport cnt (input rdy, bofs_x, bofs_y, mofs_start, ystep, bound_x, bound_y,
		output ack);
endinterface

// One warp of lane addresses with its lane mask
interface warp_if
	import tau_types_pkg::*;
();
	logic       rdy;
	logic       ack;
	gaddr_t     addr [`VSIZE];
	lane_mask_t valid;

	modport src (output rdy, addr, valid, input ack);
	modport dst (input rdy, addr, valid, output ack);
endinterface

`default_nettype wire

// File: verilog/tau_types_pkg.sv
`default_nettype none

`include "tau_consts.svh"

package tau_types_pkg;

	// Global word address into DRAM
	typedef logic [`GBW-1:0] gaddr_t;

	// One ALU result or DRAM word
	typedef logic [`DBW-1:0] data_t;

	// Block offset or boundary coordinate
	typedef logic [`WBW-1:0] coord_t;

	// One valid bit per lane of a warp
	typedef logic [`VSIZE-1:0] lane_mask_t;

	// One write enable per word of a DRAM line
	typedef logic [`CSIZE-1:0] line_mask_t;

endpackage

`default_nettype wire

// File: verilog/warp_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

module warp_addr_counter
	import tau_types_pkg::*;
(
	input  wire      i_clk,
	input  wire      i_rst,
	block_cmd_if.cnt cmd,
	warp_if.src      warp
);

localparam ROW_BW = $clog2(`BLK_ROWS);

//==================================================
// Row counter
//==================================================
logic              busy;
logic              ack_r;
logic [ROW_BW-1:0] row;
gaddr_t            row_base;
logic              start;
logic              fire;
logic              last_row;

// ack_r blocks a restart while the sequencer still holds rdy
assign start    = !busy && cmd.rdy && !ack_r;
assign fire     = warp.rdy && warp.ack;
assign last_row = (row == ROW_BW'(`BLK_ROWS-1));

assign warp.rdy = busy;
assign cmd.ack  = ack_r;

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		busy  <= 1'b0;
		ack_r <= 1'b0;
		row   <= '0;
	end else begin
		ack_r <= 1'b0;
		if (start) begin
			busy <= 1'b1;
			row  <= '0;
		end else if (fire) begin
			if (last_row) begin
				busy  <= 1'b0;
				ack_r <= 1'b1;
			end else begin
				row <= row + 1'b1;
			end
		end
	end
end

// One multiply per block, then each row steps by ystep
always_ff @(posedge i_clk) begin
	if (start) begin
		row_base <= cmd.mofs_start + gaddr_t'(cmd.bofs_x) + gaddr_t'(cmd.bofs_y) * cmd.ystep;
	end else if (fire) begin
		row_base <= row_base + cmd.ystep;
	end
end

//==================================================
// Lane addresses and boundary mask
//==================================================
logic [`WBW:0] row_y;
logic [`WBW:0] lane_x;

always_comb begin
	row_y = {1'b0, cmd.bofs_y} + (`WBW+1)'(row);
	for (int l = 0; l < `VSIZE; l++) begin
		lane_x       = {1'b0, cmd.bofs_x} + (`WBW+1)'(l);
		warp.addr[l] = row_base + gaddr_t'(l);
		warp.valid[l] = (lane_x < {1'b0, cmd.bound_x}) && (row_y < {1'b0, cmd.bound_y});
	end
end

endmodule

`default_nettype wire

// File: verilog/write_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "tau_consts.svh"

module write_pipeline
	import tau_types_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	// Block command
	input  wire         i_bofs_rdy,
	output logic        o_bofs_ack,
	input  wire coord_t i_bofs_x,
	input  wire coord_t i_bofs_y,
	input  wire gaddr_t i_mofs_start,
	input  wire gaddr_t i_ystep,
	input  wire coord_t i_bound_x,
	input  wire coord_t i_bound_y,
	// ALU results
	input  wire         i_alu_dat_rdy,
	output logic        o_alu_dat_ack,
	input  wire data_t  i_alu_dat [`VSIZE],
	// Block done
	input  wire         i_blkdone_dval,
	// DRAM write
	output logic        o_dramw_rdy,
	input  wire         i_dramw_ack,
	output gaddr_t      o_dramwa,
	output data_t       o_dramwd [`CSIZE],
	output line_mask_t  o_dramw_mask
);

//==================================================
// Internal links
//==================================================
block_cmd_if u_cmd_if ();
warp_if      u_warp_if ();

//==================================================
// Submodules
//==================================================
block_sequencer u_seq (
	.i_clk          (i_clk),
	.i_rst          (i_rst),
	.i_bofs_rdy     (i_bofs_rdy),
	.o_bofs_ack     (o_bofs_ack),
	.i_bofs_x       (i_bofs_x),
	.i_bofs_y       (i_bofs_y),
	.i_mofs_start   (i_mofs_start),
	.i_ystep        (i_ystep),
	.i_bound_x      (i_bound_x),
	.i_bound_y      (i_bound_y),
	.i_blkdone_dval (i_blkdone_dval),
	.cmd            (u_cmd_if.seq)
);

warp_addr_counter u_cnt (
	.i_clk (i_clk),
	.i_rst (i_rst),
	.cmd   (u_cmd_if.cnt),
	.warp  (u_warp_if.src)
);

dram_write_collector u_dwc (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.warp          (u_warp_if.dst),
	.i_alu_dat_rdy (i_alu_dat_rdy),
	.o_alu_dat_ack (o_alu_dat_ack),
	.i_alu_dat     (i_alu_dat),
	.o_dramw_rdy   (o_dramw_rdy),
	.i_dramw_ack   (i_dramw_ack),
	.o_dramwa      (o_dramwa),
	.o_dramwd      (o_dramwd),
	.o_dramw_mask  (o_dramw_mask)
);

endmodule

`default_nettype wire
